/* alu_fu_defs.svh */
`ifndef ALU_FU_DEFS_SVH
`define ALU_FU_DEFS_SVH

// datapath and tag widths
`define ALU_XLEN      32
`define ALU_TAG_W     5
`define ALU_OPC_W     12
`define ALU_OP_W      4

// opcode word split, major in the upper bits
`define ALU_MAJ_W     6
`define ALU_FN_W      6
// shifts only look at the low bits of b
`define ALU_SHAMT_W   5

// major opcodes
`define OPC_RTYPE     6'h00
`define OPC_BEQ       6'h04
`define OPC_BNE       6'h05

// function field under OPC_RTYPE
`define FN_ADD        6'h20
`define FN_SUB        6'h22
`define FN_AND        6'h24
`define FN_OR         6'h25
`define FN_XOR        6'h26
`define FN_NOR        6'h27
`define FN_SLL        6'h00
`define FN_SRL        6'h02
`define FN_SLT        6'h2a
`define FN_SGT        6'h2b

// alu operation codes, same numbering as the original alu block
`define ALU_OP_ADD    4'd0
`define ALU_OP_SUB    4'd1
`define ALU_OP_AND    4'd2
`define ALU_OP_OR     4'd3
`define ALU_OP_XOR    4'd4
`define ALU_OP_NOR    4'd5
`define ALU_OP_SLL    4'd6
`define ALU_OP_SRL    4'd7
`define ALU_OP_SLT    4'd8
`define ALU_OP_SGT    4'd9

`endif

/* alu_fu_pkg.sv */
`include "alu_fu_defs.svh"

package alu_fu_pkg;

    // operand or result word
    typedef logic [`ALU_XLEN-1:0] xlen_t;

    // reorder buffer tag, zero means no instruction
    typedef logic [`ALU_TAG_W-1:0] rob_tag_t;

    // major opcode in the top bits, function field below
    typedef logic [`ALU_OPC_W-1:0] opcode_word_t;

    // operation selected by decode
    typedef enum logic [`ALU_OP_W-1:0] {
        op_add = `ALU_OP_ADD,
        op_sub = `ALU_OP_SUB,
        op_and = `ALU_OP_AND,
        op_or  = `ALU_OP_OR,
        op_xor = `ALU_OP_XOR,
        op_nor = `ALU_OP_NOR,
        op_sll = `ALU_OP_SLL,
        op_srl = `ALU_OP_SRL,
        op_slt = `ALU_OP_SLT,
        op_sgt = `ALU_OP_SGT
    } alu_op_e;

    // which branch test, if any, applies to the result
    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_beq  = 2'd1,
        br_bne  = 2'd2
    } branch_kind_e;

endpackage

/* alu_decode.sv */
`timescale 1ns/1ps
`include "alu_fu_defs.svh"

module alu_decode (
    input  alu_fu_pkg::opcode_word_t opcode,
    output alu_fu_pkg::alu_op_e      op,
    output alu_fu_pkg::branch_kind_e branch,
    output logic                     illegal
);
    import alu_fu_pkg::*;

    logic [`ALU_MAJ_W-1:0] major;
    logic [`ALU_FN_W-1:0]  funct;

    // split the opcode word
    assign major = opcode[`ALU_OPC_W-1 -: `ALU_MAJ_W];
    assign funct = opcode[`ALU_FN_W-1:0];

    always_comb begin
        // add keeps the datapath defined on a bad opcode
        op      = op_add;
        branch  = br_none;
        illegal = 1'b0;
        case (major)
            `OPC_RTYPE: begin
                // register-register, function field picks the op
                case (funct)
                    `FN_ADD: op = op_add;
                    `FN_SUB: op = op_sub;
                    `FN_AND: op = op_and;
                    `FN_OR:  op = op_or;
                    `FN_XOR: op = op_xor;
                    `FN_NOR: op = op_nor;
                    `FN_SLL: op = op_sll;
                    `FN_SRL: op = op_srl;
                    `FN_SLT: op = op_slt;
                    `FN_SGT: op = op_sgt;
                    default: begin
                        // unknown function value
                        illegal = 1'b1;
                    end
                endcase
            end
            `OPC_BEQ: begin
                // compare by subtraction, function field ignored
                op     = op_sub;
                branch = br_beq;
            end
            `OPC_BNE: begin
                op     = op_sub;
                branch = br_bne;
            end
            default: begin
                // unknown major opcode
                illegal = 1'b1;
            end
        endcase
    end

endmodule

/* alu_exec.sv */
`timescale 1ns/1ps
`include "alu_fu_defs.svh"

module alu_exec (
    input  logic                     clk,
    input  logic                     rst,
    input  alu_fu_pkg::rob_tag_t     issue_tag,
    input  alu_fu_pkg::alu_op_e      op,
    input  alu_fu_pkg::branch_kind_e branch,
    input  logic                     illegal,
    input  alu_fu_pkg::xlen_t        a,
    input  alu_fu_pkg::xlen_t        b,
    output logic                     fu_free,
    output logic                     ex_valid,
    output alu_fu_pkg::rob_tag_t     ex_tag,
    output alu_fu_pkg::xlen_t        ex_value,
    output logic                     ex_taken,
    output logic                     ex_illegal
);
    import alu_fu_pkg::*;

    logic                    busy_q;
    logic                    accept;
    alu_op_e                 op_q;
    branch_kind_e            branch_q;
    xlen_t                   a_q;
    xlen_t                   b_q;
    logic [`ALU_SHAMT_W-1:0] shamt;

    // take the instruction when idle and the tag is real
    assign accept = ~busy_q && (issue_tag != '0);

    // busy for exactly the cycle after an accepted issue
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= accept;
        end
    end

    // one instruction in execute while busy
    assign fu_free  = ~busy_q;
    assign ex_valid = busy_q;

    // held instruction, only read while ex_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            ex_tag     <= issue_tag;
            op_q       <= op;
            branch_q   <= branch;
            ex_illegal <= illegal;
            a_q        <= a;
            b_q        <= b;
        end
    end

    // low bits of b only
    assign shamt = b_q[`ALU_SHAMT_W-1:0];

    always_comb begin
        case (op_q)
            op_add:  ex_value = a_q + b_q;
            op_sub:  ex_value = a_q - b_q;
            op_and:  ex_value = a_q & b_q;
            op_or:   ex_value = a_q | b_q;
            op_xor:  ex_value = a_q ^ b_q;
            op_nor:  ex_value = ~(a_q | b_q);
            op_sll:  ex_value = a_q << shamt;
            op_srl:  ex_value = a_q >> shamt;
            // signed compares, result 0 or 1
            op_slt:  ex_value = xlen_t'($signed(a_q) < $signed(b_q));
            op_sgt:  ex_value = xlen_t'($signed(a_q) > $signed(b_q));
            default: ex_value = '0;
        endcase
    end

    // branch decision straight from the operands
    always_comb begin
        case (branch_q)
            br_beq:  ex_taken = (a_q == b_q);
            br_bne:  ex_taken = (a_q != b_q);
            default: ex_taken = 1'b0;
        endcase
    end

endmodule

/* alu_result.sv */
`timescale 1ns/1ps

module alu_result (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_valid,
    input  alu_fu_pkg::rob_tag_t ex_tag,
    input  alu_fu_pkg::xlen_t    ex_value,
    input  logic                 ex_taken,
    input  logic                 ex_illegal,
    output logic                 cdb_valid,
    output alu_fu_pkg::rob_tag_t cdb_tag,
    output alu_fu_pkg::xlen_t    cdb_value,
    output logic                 cdb_branch_taken,
    output logic                 cdb_illegal
);

    // broadcast slot, one cycle per instruction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb_valid        <= 1'b0;
            cdb_tag          <= '0;
            cdb_value        <= '0;
            cdb_branch_taken <= 1'b0;
            cdb_illegal      <= 1'b0;
        end else if (ex_valid) begin
            // latch the finished instruction
            cdb_valid        <= 1'b1;
            cdb_tag          <= ex_tag;
            cdb_value        <= ex_value;
            cdb_branch_taken <= ex_taken;
            cdb_illegal      <= ex_illegal;
        end else begin
            // idle bus shows tag zero and zero payload
            cdb_valid        <= 1'b0;
            cdb_tag          <= '0;
            cdb_value        <= '0;
            cdb_branch_taken <= 1'b0;
            cdb_illegal      <= 1'b0;
        end
    end

endmodule

/* alu_fu_top.sv */
`timescale 1ns/1ps

module alu_fu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  alu_fu_pkg::rob_tag_t     issue_tag,
    input  alu_fu_pkg::opcode_word_t issue_opcode,
    input  alu_fu_pkg::xlen_t        issue_a,
    input  alu_fu_pkg::xlen_t        issue_b,
    output logic                     fu_free,
    output logic                     cdb_valid,
    output alu_fu_pkg::rob_tag_t     cdb_tag,
    output alu_fu_pkg::xlen_t        cdb_value,
    output logic                     cdb_branch_taken,
    output logic                     cdb_illegal
);
    import alu_fu_pkg::*;

    // decode to execute
    alu_op_e      dec_op;
    branch_kind_e dec_branch;
    logic         dec_illegal;

    // execute to result
    logic         ex_valid;
    rob_tag_t     ex_tag;
    xlen_t        ex_value;
    logic         ex_taken;
    logic         ex_illegal;

    // combinational decode of the incoming opcode
    alu_decode u_decode (
        .opcode  (issue_opcode),
        .op      (dec_op),
        .branch  (dec_branch),
        .illegal (dec_illegal)
    );

    alu_exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .issue_tag  (issue_tag),
        .op         (dec_op),
        .branch     (dec_branch),
        .illegal    (dec_illegal),
        .a          (issue_a),
        .b          (issue_b),
        .fu_free    (fu_free),
        .ex_valid   (ex_valid),
        .ex_tag     (ex_tag),
        .ex_value   (ex_value),
        .ex_taken   (ex_taken),
        .ex_illegal (ex_illegal)
    );

    // common data bus driver
    alu_result u_result (
        .clk              (clk),
        .rst              (rst),
        .ex_valid         (ex_valid),
        .ex_tag           (ex_tag),
        .ex_value         (ex_value),
        .ex_taken         (ex_taken),
        .ex_illegal       (ex_illegal),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        .cdb_branch_taken (cdb_branch_taken),
        .cdb_illegal      (cdb_illegal)
    );

endmodule

/* tb_alu_fu.sv */
`timescale 1ns/1ps
`include "alu_fu_defs.svh"

module tb_alu_fu;
    import alu_fu_pkg::*;

    localparam int N_RANDOM = 200;
    // 50 directed ops, 4 branches, 4 illegal, 3 zero tag
    localparam int N_SENDS = N_RANDOM + 61;
    localparam int TIMEOUT_CYCLES = 4 * N_SENDS + 100;

    logic         clk;
    logic         rst;
    rob_tag_t     issue_tag;
    opcode_word_t issue_opcode;
    xlen_t        issue_a;
    xlen_t        issue_b;
    logic         fu_free;
    logic         cdb_valid;
    rob_tag_t     cdb_tag;
    xlen_t        cdb_value;
    logic         cdb_branch_taken;
    logic         cdb_illegal;

    int          errors = 0;
    int          checks = 0;
    int          cyc = 0;
    int          pending = 0;
    // an issue was taken at the last rising edge
    logic        accepted_last = 1'b0;
    logic [31:0] rng = 32'h1ac0;
    rob_tag_t    next_tag = 5'd1;
    // expected broadcasts in issue order, result is {illegal, taken, value}
    rob_tag_t    exp_tag_q[$];
    logic [33:0] exp_res_q[$];
    int          exp_cyc_q[$];

    logic [5:0] fn_tab [10] = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR,
                                `FN_NOR, `FN_SLL, `FN_SRL, `FN_SLT, `FN_SGT};
    // signed edges, shifts of 31, 5 and 32
    xlen_t dir_a [5] = '{32'h7fffffff, 32'h80000000, 32'h12345678, 32'h00000005, 32'hfffffff0};
    xlen_t dir_b [5] = '{32'h00000001, 32'hffffffff, 32'h00000025, 32'h00000005, 32'h00000020};
    xlen_t edge_tab [5] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};

    alu_fu_top dut (
        .clk              (clk),
        .rst              (rst),
        .issue_tag        (issue_tag),
        .issue_opcode     (issue_opcode),
        .issue_a          (issue_a),
        .issue_b          (issue_b),
        .fu_free          (fu_free),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        .cdb_branch_taken (cdb_branch_taken),
        .cdb_illegal      (cdb_illegal)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic rob_tag_t alloc_tag();
        rob_tag_t t;
        t = next_tag;
        // tags cycle through 1..31
        next_tag = (next_tag == 5'd31) ? 5'd1 : next_tag + 5'd1;
        return t;
    endfunction

    // expected {illegal, taken, value} for one instruction
    function automatic logic [33:0] ref_alu(input opcode_word_t opc, input xlen_t a,
                                            input xlen_t b);
        logic [5:0] maj;
        logic [5:0] fn;
        xlen_t      v;
        logic       t;
        logic       ill;
        maj = opc[11:6];
        fn  = opc[5:0];
        v   = a + b;
        t   = 1'b0;
        ill = 1'b0;
        if (maj == `OPC_RTYPE) begin
            case (fn)
                `FN_ADD: v = a + b;
                `FN_SUB: v = a - b;
                `FN_AND: v = a & b;
                `FN_OR:  v = a | b;
                `FN_XOR: v = a ^ b;
                `FN_NOR: v = ~(a | b);
                `FN_SLL: v = a << b[4:0];
                `FN_SRL: v = a >> b[4:0];
                `FN_SLT: v = {31'b0, $signed(a) < $signed(b)};
                `FN_SGT: v = {31'b0, $signed(a) > $signed(b)};
                default: ill = 1'b1;
            endcase
        end else if (maj == `OPC_BEQ || maj == `OPC_BNE) begin
            v = a - b;
            t = (maj == `OPC_BEQ) ? (a == b) : (a != b);
        end else begin
            ill = 1'b1;
        end
        return {ill, t, v};
    endfunction

    task automatic compare_field(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
        checks++;
        if (got !== want) begin
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, want, got);
            errors++;
        end
    endtask

    // caller sits at a rising edge, returns at the edge that takes the issue
    task automatic send(input rob_tag_t tag, input opcode_word_t opc, input xlen_t a,
                        input xlen_t b);
        issue_tag    <= tag;
        issue_opcode <= opc;
        issue_a      <= a;
        issue_b      <= b;
        @(negedge clk);
        // hold the issue while the unit is busy
        while (tag != '0 && !fu_free) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic send_random();
        logic [31:0]  r;
        logic [3:0]   sel;
        xlen_t        a;
        xlen_t        b;
        opcode_word_t opc;
        r   = next_rand();
        sel = r[3:0];
        a   = r[4] ? edge_tab[r[7:5] % 3'd5] : next_rand();
        b   = r[8] ? edge_tab[r[11:9] % 3'd5] : next_rand();
        // equal operands for the branch compare
        if (r[12]) b = a;
        if (sel < 4'd10) opc = {`OPC_RTYPE, fn_tab[sel]};
        else if (sel < 4'd12) opc = {`OPC_BEQ, r[21:16]};
        else if (sel < 4'd14) opc = {`OPC_BNE, r[21:16]};
        else if (sel == 4'd14) opc = {2'b11, r[19:16], r[21:16]};
        else opc = {`OPC_RTYPE, 2'b01, r[19:16]};
        send(alloc_tag(), opc, a, b);
    endtask

    // busy flag, then accepted issues, then the bus
    always @(negedge clk) begin
        logic [33:0] want;
        // low for exactly the cycle after an accepted issue
        if (!rst) begin
            compare_field("fu_free", 32'(!accepted_last), 32'(fu_free));
        end
        accepted_last = !rst && fu_free && issue_tag != '0;
        if (accepted_last) begin
            exp_tag_q.push_back(issue_tag);
            exp_res_q.push_back(ref_alu(issue_opcode, issue_a, issue_b));
            exp_cyc_q.push_back(cyc + 2);
            pending++;
        end
        if (cdb_valid) begin
            if (exp_tag_q.size() == 0) begin
                $display("unexpected broadcast of tag %0d at %0t", cdb_tag, $time);
                errors++;
            end else begin
                if (exp_cyc_q[0] != cyc) begin
                    $display("tag %0d broadcast in cycle %0d, expected cycle %0d",
                             cdb_tag, cyc, exp_cyc_q[0]);
                    errors++;
                end
                want = exp_res_q.pop_front();
                compare_field("cdb_tag", 32'(exp_tag_q.pop_front()), 32'(cdb_tag));
                compare_field("cdb_value", want[31:0], cdb_value);
                compare_field("cdb_branch_taken", 32'(want[32]), 32'(cdb_branch_taken));
                compare_field("cdb_illegal", 32'(want[33]), 32'(cdb_illegal));
                void'(exp_cyc_q.pop_front());
                pending--;
            end
        end else begin
            if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc) begin
                $display("tag %0d was never broadcast", exp_tag_q[0]);
                errors++;
                void'(exp_tag_q.pop_front());
                void'(exp_res_q.pop_front());
                void'(exp_cyc_q.pop_front());
                pending--;
            end
            // idle bus is all zero
            compare_field("cdb_tag", 32'h0, 32'(cdb_tag));
            compare_field("cdb_value", 32'h0, cdb_value);
            compare_field("cdb_branch_taken", 32'h0, 32'(cdb_branch_taken));
            compare_field("cdb_illegal", 32'h0, 32'(cdb_illegal));
        end
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
        errors++;
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        issue_tag    = '0;
        issue_opcode = '0;
        issue_a      = '0;
        issue_b      = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_field("fu_free", 32'h1, 32'(fu_free));
        compare_field("cdb_valid", 32'h0, 32'(cdb_valid));
        @(posedge clk);
        // every operation against the edge operands
        for (int i = 0; i < 10; i++) begin
            for (int j = 0; j < 5; j++) begin
                send(alloc_tag(), {`OPC_RTYPE, fn_tab[i]}, dir_a[j], dir_b[j]);
            end
        end
        // branches, function field is don't care
        send(alloc_tag(), {`OPC_BEQ, 6'h15}, 32'd7, 32'd7);
        send(alloc_tag(), {`OPC_BEQ, 6'h00}, 32'd7, 32'd8);
        send(alloc_tag(), {`OPC_BNE, 6'h15}, 32'd7, 32'd7);
        send(alloc_tag(), {`OPC_BNE, 6'h00}, 32'd7, 32'd8);
        // bad major opcodes, then bad function values
        send(alloc_tag(), {6'h3f, `FN_ADD}, 32'd3, 32'd4);
        send(alloc_tag(), {6'h01, `FN_ADD}, 32'd3, 32'd4);
        send(alloc_tag(), {`OPC_RTYPE, 6'h3f}, 32'd3, 32'd4);
        send(alloc_tag(), {`OPC_RTYPE, 6'h01}, 32'd3, 32'd4);
        // zero tag must stay off the bus
        repeat (3) send('0, {`OPC_RTYPE, `FN_ADD}, 32'd1, 32'd2);
        for (int n = 0; n < N_RANDOM; n++) send_random();
        issue_tag <= '0;
        while (pending != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* alu_fu.f */
+incdir+.
alu_fu_pkg.sv
alu_decode.sv
alu_exec.sv
alu_result.sv
alu_fu_top.sv
tb_alu_fu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_alu_fu
FILELIST  := alu_fu.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
